/* logic/rv_decode_pkg.sv */
// machine mode only; jumps link pc+4 in execute, src1_sel picks the jump target base
package rv_decode_pkg;

  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int GPR_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;

  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;
  localparam logic [XLEN-1:0]       MCAUSE_ECALL_M = 64'd11;
  localparam logic [GPR_ADDR_W-1:0] GPR_A0 = 5'd10;  // ebreak argument

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG32  = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;

  localparam logic       SRC1_RS1  = 1'b0;
  localparam logic       SRC1_PC   = 1'b1;  // zimm for the csr immediate forms
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JUMP
  } br_func_e;

  typedef enum logic [2:0] {
    CSR_OP_NONE, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR
  } csr_op_e;

  typedef struct packed {
    logic       src1_sel;
    logic [1:0] src2_sel;
    logic       word_op;     // W variants, sign-extend low word
    alu_op_e    alu_op;
    br_func_e   br_func;
    logic       gpr_wen;
    logic       csr_ren;
    logic       csr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;      // funct3 of load/store
    logic       csr_to_gpr;
    csr_op_e    csr_op;
    logic       ebreak;
    logic       ecall;
    logic       mret;
    logic       invalid;
  } ctrl_t;

  typedef struct packed {
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   pc;
  } fetch_pkt_t;

  typedef struct packed {
    logic                  gpr_wen;
    logic [GPR_ADDR_W-1:0] gpr_waddr;
    logic [XLEN-1:0]       gpr_wdata;
    logic                  csr_wen;
    logic [CSR_ADDR_W-1:0] csr_waddr;
    logic [XLEN-1:0]       csr_wdata;
  } wb_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0]       rs1data;
    logic [XLEN-1:0]       rs2data;
    logic [XLEN-1:0]       csrrdata;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    logic [INST_W-1:0]     inst;
    logic [GPR_ADDR_W-1:0] rd;
    logic [CSR_ADDR_W-1:0] csr;
    ctrl_t                 ctrl;
  } issue_pkt_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } redirect_t;

  // zero means no destination in that stage
  typedef struct packed {
    logic [GPR_ADDR_W-1:0] es_rd;
    logic [GPR_ADDR_W-1:0] ms_rd;
    logic [GPR_ADDR_W-1:0] ws_rd;
    logic [CSR_ADDR_W-1:0] es_csr;
    logic [CSR_ADDR_W-1:0] ms_csr;
    logic [CSR_ADDR_W-1:0] ws_csr;
  } inflight_t;

endpackage

/* logic/inst_decoder.sv */
// RV64I + Zicsr + ecall/ebreak/mret only; fence decodes as a no-op, the rest is invalid
`timescale 1ns/1ps

module inst_decoder import rv_decode_pkg::*; (
  input  logic [INST_W-1:0]     i_inst,
  output logic [GPR_ADDR_W-1:0] o_rs1,
  output logic [GPR_ADDR_W-1:0] o_rs2,
  output logic [GPR_ADDR_W-1:0] o_rd,
  output logic [XLEN-1:0]       o_imm,
  output logic [CSR_ADDR_W-1:0] o_csr,
  output ctrl_t                 o_ctrl
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            bad;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = o_ctrl.gpr_wen ? i_inst[11:7] : '0;

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  function automatic alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic csr_op_e csr_op_of(input logic [1:0] f3_lo);
    case (f3_lo)
      2'b01:   return CSR_OP_WRITE;
      2'b10:   return CSR_OP_SET;
      2'b11:   return CSR_OP_CLEAR;
      default: return CSR_OP_NONE;
    endcase
  endfunction

  always_comb begin
    o_ctrl = '0;
    o_imm  = '0;
    o_csr  = '0;
    bad    = 1'b0;
    case (opcode)
      OP_LUI, OP_AUIPC: begin
        o_ctrl.src1_sel = (opcode == OP_AUIPC) ? SRC1_PC : SRC1_RS1;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.alu_op   = (opcode == OP_LUI) ? ALU_LUI : ALU_ADD;
        o_ctrl.gpr_wen  = 1'b1;
        o_imm           = imm_u;
      end
      OP_JAL, OP_JALR: begin
        o_ctrl.src1_sel = (opcode == OP_JAL) ? SRC1_PC : SRC1_RS1;  // target base
        o_ctrl.src2_sel = SRC2_FOUR;
        o_ctrl.br_func  = BR_JUMP;
        o_ctrl.gpr_wen  = 1'b1;
        o_imm           = (opcode == OP_JAL) ? imm_j : imm_i;
        bad             = (opcode == OP_JALR) && (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        o_ctrl.src1_sel = SRC1_PC;
        o_imm           = imm_b;
        case (funct3)
          3'b000:  o_ctrl.br_func = BR_BEQ;
          3'b001:  o_ctrl.br_func = BR_BNE;
          3'b100:  o_ctrl.br_func = BR_BLT;
          3'b101:  o_ctrl.br_func = BR_BGE;
          3'b110:  o_ctrl.br_func = BR_BLTU;
          3'b111:  o_ctrl.br_func = BR_BGEU;
          default: bad = 1'b1;
        endcase
      end
      OP_LOAD, OP_STORE: begin
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.mem_op   = funct3;
        o_ctrl.mem_ren  = (opcode == OP_LOAD);
        o_ctrl.mem_wen  = (opcode == OP_STORE);
        o_ctrl.gpr_wen  = (opcode == OP_LOAD);
        o_imm           = (opcode == OP_LOAD) ? imm_i : imm_s;
        bad = (opcode == OP_LOAD) ? (funct3 == 3'b111) : funct3[2];
      end
      OP_IMM, OP_IMM32: begin
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.word_op  = (opcode == OP_IMM32);
        o_ctrl.alu_op   = alu_of(funct3, funct3 == 3'b101 && i_inst[30]);
        o_ctrl.gpr_wen  = 1'b1;
        o_imm           = imm_i;
        if (opcode == OP_IMM) begin  // 6-bit shamt
          bad = (funct3 == 3'b001 && i_inst[31:26] != '0)
             || (funct3 == 3'b101 && {i_inst[31], i_inst[29:26]} != '0);
        end else begin
          bad = !(funct3 inside {3'b000, 3'b001, 3'b101})
             || (funct3 == 3'b001 && funct7 != '0)
             || (funct3 == 3'b101 && {funct7[6], funct7[4:0]} != '0);
        end
      end
      OP_REG, OP_REG32: begin
        o_ctrl.src2_sel = SRC2_RS2;
        o_ctrl.word_op  = (opcode == OP_REG32);
        o_ctrl.alu_op   = alu_of(funct3, funct7[5]);
        o_ctrl.gpr_wen  = 1'b1;
        bad = ({funct7[6], funct7[4:0]} != '0)
           || (funct7[5] && !(funct3 inside {3'b000, 3'b101}))
           || (o_ctrl.word_op && !(funct3 inside {3'b000, 3'b001, 3'b101}));
      end
      OP_SYSTEM: begin
        if (funct3 == 3'b000) begin
          case (i_inst)
            32'h0000_0073: begin
              o_ctrl.ecall = 1'b1;
              o_csr        = CSR_MTVEC;  // trap vector read
            end
            32'h0010_0073: o_ctrl.ebreak = 1'b1;
            32'h3020_0073: begin
              o_ctrl.mret = 1'b1;
              o_csr       = CSR_MEPC;
            end
            default: bad = 1'b1;
          endcase
        end else if (funct3 == 3'b100) begin
          bad = 1'b1;
        end else begin
          o_csr             = i_inst[31:20];
          o_ctrl.src1_sel   = funct3[2] ? SRC1_PC : SRC1_RS1;
          o_ctrl.csr_ren    = 1'b1;
          o_ctrl.csr_to_gpr = 1'b1;
          o_ctrl.gpr_wen    = 1'b1;
          o_ctrl.csr_op     = csr_op_of(funct3[1:0]);
          // set/clear with a zero source leave the csr alone
          o_ctrl.csr_wen    = (funct3[1:0] == 2'b01) || (i_inst[19:15] != '0);
          o_imm             = {{(XLEN-5){1'b0}}, i_inst[19:15]};
        end
      end
      OP_FENCE: ;  // in-order, nothing to order
      default: bad = 1'b1;
    endcase
    if (bad) begin
      o_ctrl         = '0;
      o_ctrl.invalid = 1'b1;
    end
  end

  a_one_special: assert final ($onehot0({o_ctrl.ecall, o_ctrl.ebreak, o_ctrl.mret,
                                         o_ctrl.invalid}))
    else $error("decoder raised more than one of ecall, ebreak, mret, invalid");

endmodule

/* logic/gpr_file.sv */
// no bypass: a read in the write cycle returns the old value; x0 reads zero
`timescale 1ns/1ps

module gpr_file import rv_decode_pkg::*; (
  input  logic                  i_clk,
  input  logic [GPR_ADDR_W-1:0] i_raddr1,
  output logic [XLEN-1:0]       o_rdata1,
  input  logic [GPR_ADDR_W-1:0] i_raddr2,
  output logic [XLEN-1:0]       o_rdata2,
  input  logic                  i_wen,
  input  logic [GPR_ADDR_W-1:0] i_waddr,
  input  logic [XLEN-1:0]       i_wdata
);

  logic [XLEN-1:0] regs [2**GPR_ADDR_W];

  // entry 0 is never written
  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* logic/csr_file.sv */
// mstatus/mtvec/mepc/mcause only; mret leaves mstatus alone, unknown CSRs read zero
`timescale 1ns/1ps

module csr_file import rv_decode_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [CSR_ADDR_W-1:0] i_raddr,
  output logic [XLEN-1:0]       o_rdata,
  input  logic                  i_wen,
  input  logic [CSR_ADDR_W-1:0] i_waddr,
  input  logic [XLEN-1:0]       i_wdata,
  input  logic                  i_trap,
  input  logic [XLEN-1:0]       i_trap_pc,
  output logic [XLEN-1:0]       o_mtvec,
  output logic [XLEN-1:0]       o_mepc
);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (i_wen) begin
        case (i_waddr)
          CSR_MSTATUS: mstatus <= i_wdata;
          CSR_MTVEC:   mtvec   <= i_wdata;
          CSR_MEPC:    mepc    <= i_wdata;
          CSR_MCAUSE:  mcause  <= i_wdata;
          default: ;
        endcase
      end
      if (i_trap) begin  // last assignment wins over write-back
        mepc   <= i_trap_pc;
        mcause <= MCAUSE_ECALL_M;
      end
    end
  end

  always_comb begin
    case (i_raddr)
      CSR_MSTATUS: o_rdata = mstatus;
      CSR_MTVEC:   o_rdata = mtvec;
      CSR_MEPC:    o_rdata = mepc;
      CSR_MCAUSE:  o_rdata = mcause;
      default:     o_rdata = '0;
    endcase
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

  // trap comes from an issuing ecall, which the stage cannot produce in reset
  a_no_trap_in_rst: assert property (@(posedge i_clk) i_rst |-> !i_trap)
    else $error("trap update requested during reset");

endmodule

/* logic/branch_unit.sv */
// resolves in decode with no prediction; jalr is the jump whose base is rs1
`timescale 1ns/1ps

module branch_unit import rv_decode_pkg::*; (
  input  logic            i_issue,
  input  ctrl_t           i_ctrl,
  input  logic [XLEN-1:0] i_rs1data,
  input  logic [XLEN-1:0] i_rs2data,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_imm,
  input  logic [XLEN-1:0] i_mtvec,
  input  logic [XLEN-1:0] i_mepc,
  output redirect_t       o_redirect
);

  logic            cond;
  logic            reg_base;
  logic [XLEN-1:0] jump_sum;

  assign reg_base = (i_ctrl.src1_sel == SRC1_RS1);
  assign jump_sum = (reg_base ? i_rs1data : i_pc) + i_imm;

  always_comb begin
    case (i_ctrl.br_func)
      BR_BEQ:  cond = (i_rs1data == i_rs2data);
      BR_BNE:  cond = (i_rs1data != i_rs2data);
      BR_BLT:  cond = ($signed(i_rs1data) < $signed(i_rs2data));
      BR_BGE:  cond = ($signed(i_rs1data) >= $signed(i_rs2data));
      BR_BLTU: cond = (i_rs1data < i_rs2data);
      BR_BGEU: cond = (i_rs1data >= i_rs2data);
      BR_JUMP: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    o_redirect.taken = i_issue && (cond || i_ctrl.ecall || i_ctrl.mret);
    if (i_ctrl.ecall) begin
      o_redirect.target = i_mtvec;
    end else if (i_ctrl.mret) begin
      o_redirect.target = i_mepc;
    end else begin
      o_redirect.target = {jump_sum[XLEN-1:1], jump_sum[0] & !reg_base};  // jalr drops bit 0
    end
  end

endmodule

/* logic/decode_stage.sv */
// single-entry decode stage; no forwarding, stalls until in-flight producers clear
`timescale 1ns/1ps

module decode_stage import rv_decode_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_fs_valid,
  input  fetch_pkt_t i_fs_pkt,
  output logic       o_ds_allowin,
  output logic       o_ds_valid,
  output issue_pkt_t o_ds_pkt,
  input  logic       i_es_allowin,
  output redirect_t  o_redirect,
  input  wb_pkt_t    i_wb,
  input  inflight_t  i_inflight
);

  logic                  ds_valid;
  fetch_pkt_t            ds_pkt_r;
  logic                  ready_go;
  logic                  issue;
  logic                  gpr_hazard;
  logic                  csr_hazard;
  logic [GPR_ADDR_W-1:0] rs1;
  logic [GPR_ADDR_W-1:0] rs2;
  logic [GPR_ADDR_W-1:0] rd;
  logic [CSR_ADDR_W-1:0] csr;
  logic [XLEN-1:0]       imm;
  logic [XLEN-1:0]       rs1data;
  logic [XLEN-1:0]       rs2data;
  logic [XLEN-1:0]       csrrdata;
  logic [XLEN-1:0]       mtvec;
  logic [XLEN-1:0]       mepc;
  ctrl_t                 ctrl;

  function automatic logic gpr_clash(input logic [GPR_ADDR_W-1:0] dst,
                                     input logic [GPR_ADDR_W-1:0] s1,
                                     input logic [GPR_ADDR_W-1:0] s2,
                                     input logic                  is_ebreak);
    return (dst != '0) && (is_ebreak ? (dst == GPR_A0) : (dst == s1 || dst == s2));
  endfunction

  // csr is zero when nothing is read, and zero never matches
  function automatic logic csr_clash(input logic [CSR_ADDR_W-1:0] dst,
                                     input logic [CSR_ADDR_W-1:0] src);
    return (dst != '0) && (dst == src);
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_ds_allowin && i_fs_valid) begin
      ds_pkt_r <= i_fs_pkt;
    end
  end

  assign gpr_hazard = gpr_clash(i_inflight.es_rd, rs1, rs2, ctrl.ebreak)
                   || gpr_clash(i_inflight.ms_rd, rs1, rs2, ctrl.ebreak)
                   || gpr_clash(i_inflight.ws_rd, rs1, rs2, ctrl.ebreak);
  assign csr_hazard = csr_clash(i_inflight.es_csr, csr)
                   || csr_clash(i_inflight.ms_csr, csr)
                   || csr_clash(i_inflight.ws_csr, csr);

  assign ready_go     = !(gpr_hazard || csr_hazard);
  assign o_ds_valid   = ds_valid && ready_go;
  assign o_ds_allowin = !ds_valid || (ready_go && i_es_allowin);
  assign issue        = o_ds_valid && i_es_allowin;  // qualifies redirect and trap

  inst_decoder u_dec (
    .i_inst (ds_pkt_r.inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_csr  (csr),
    .o_ctrl (ctrl)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (rs1data),
    .i_raddr2 (rs2),
    .o_rdata2 (rs2data),
    .i_wen    (i_wb.gpr_wen),
    .i_waddr  (i_wb.gpr_waddr),
    .i_wdata  (i_wb.gpr_wdata)
  );

  csr_file u_csr (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_raddr   (csr),
    .o_rdata   (csrrdata),
    .i_wen     (i_wb.csr_wen),
    .i_waddr   (i_wb.csr_waddr),
    .i_wdata   (i_wb.csr_wdata),
    .i_trap    (issue && ctrl.ecall),
    .i_trap_pc (ds_pkt_r.pc),
    .o_mtvec   (mtvec),
    .o_mepc    (mepc)
  );

  branch_unit u_bru (
    .i_issue    (issue),
    .i_ctrl     (ctrl),
    .i_rs1data  (rs1data),
    .i_rs2data  (rs2data),
    .i_pc       (ds_pkt_r.pc),
    .i_imm      (imm),
    .i_mtvec    (mtvec),
    .i_mepc     (mepc),
    .o_redirect (o_redirect)
  );

  always_comb begin
    o_ds_pkt.rs1data  = rs1data;
    o_ds_pkt.rs2data  = rs2data;
    o_ds_pkt.csrrdata = csrrdata;
    o_ds_pkt.imm      = imm;
    o_ds_pkt.pc       = ds_pkt_r.pc;
    o_ds_pkt.inst     = ds_pkt_r.inst;
    o_ds_pkt.rd       = rd;
    o_ds_pkt.csr      = csr;
    o_ds_pkt.ctrl     = ctrl;
  end

  // register reads stay put too, since any pending writer shows up as a hazard
  a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_valid && !i_es_allowin |=> $stable(o_ds_pkt))
    else $error("issue packet changed while execute held it off");

endmodule

/* tests/decode_stage_tb.sv */
// directed checks only; inputs change 1 ns after the rising edge, outputs sampled at the falling edge
`timescale 1ns/1ps

module decode_stage_tb import rv_decode_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;  // six tests under 200 cycles, plus reset and fill

  logic       i_clk;
  logic       i_rst;
  logic       i_fs_valid;
  fetch_pkt_t i_fs_pkt;
  logic       o_ds_allowin;
  logic       o_ds_valid;
  issue_pkt_t o_ds_pkt;
  logic       i_es_allowin;
  redirect_t  o_redirect;
  wb_pkt_t    i_wb;
  inflight_t  i_inflight;

  int              errors = 0;
  int              cycles = 0;
  logic [31:0]     rng_state;
  logic [XLEN-1:0] gpr_model [32];

  decode_stage dut_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_fs_valid   (i_fs_valid),
    .i_fs_pkt     (i_fs_pkt),
    .o_ds_allowin (o_ds_allowin),
    .o_ds_valid   (o_ds_valid),
    .o_ds_pkt     (o_ds_pkt),
    .i_es_allowin (i_es_allowin),
    .o_redirect   (o_redirect),
    .i_wb         (i_wb),
    .i_inflight   (i_inflight)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped accepting or issuing", cycles);
      $display("Summary: %0d errors", errors);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [XLEN-1:0] next_pc();
    rng_state = xorshift32(rng_state);
    return {32'h0, rng_state[31:2], 2'b00};
  endfunction

  function automatic logic [XLEN-1:0] init_val(input logic [4:0] idx);
    return {8'ha5, 19'd0, idx, 27'd0, idx};
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  function automatic ctrl_t alu_ctrl(input logic s1, input logic [1:0] s2, input logic word,
                                     input alu_op_e op);
    ctrl_t c;
    c = '0;
    c.src1_sel = s1;
    c.src2_sel = s2;
    c.word_op  = word;
    c.alu_op   = op;
    c.gpr_wen  = 1'b1;
    return c;
  endfunction

  function automatic ctrl_t mem_ctrl(input logic load, input logic [2:0] width);
    ctrl_t c;
    c = '0;
    c.src2_sel = SRC2_IMM;
    c.mem_op   = width;
    c.mem_ren  = load;
    c.mem_wen  = !load;
    c.gpr_wen  = load;
    return c;
  endfunction

  function automatic ctrl_t csr_ctrl(input csr_op_e op, input logic wen);
    ctrl_t c;
    c = '0;
    c.src1_sel   = SRC1_RS1;
    c.csr_ren    = 1'b1;
    c.csr_wen    = wen;
    c.csr_to_gpr = 1'b1;
    c.gpr_wen    = 1'b1;
    c.csr_op     = op;
    return c;
  endfunction

  function automatic ctrl_t br_ctrl(input br_func_e f);
    ctrl_t c;
    c = '0;
    c.src1_sel = SRC1_PC;
    c.br_func  = f;
    return c;
  endfunction

  // register fields are read for every encoding
  function automatic issue_pkt_t exp_pkt(input logic [31:0] inst);
    issue_pkt_t p;
    p = '0;
    p.inst    = inst;
    p.pc      = next_pc();
    p.rs1data = gpr_model[inst[19:15]];
    p.rs2data = gpr_model[inst[24:20]];
    return p;
  endfunction

  task automatic cmp_issue(input string name, input issue_pkt_t exp, input issue_pkt_t act);
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_redirect(input string name, input redirect_t exp, input redirect_t act);
    if (act.taken !== exp.taken || (exp.taken && act.target !== exp.target)) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic step();
    @(posedge i_clk);
    #1;
  endtask

  task automatic wb_gpr(input logic [4:0] idx, input logic [XLEN-1:0] val);
    i_wb.gpr_wen   = 1'b1;
    i_wb.gpr_waddr = idx;
    i_wb.gpr_wdata = val;
    step();
    i_wb.gpr_wen = 1'b0;
    if (idx != 5'd0) begin  // x0 stays zero
      gpr_model[idx] = val;
    end
  endtask

  task automatic wb_csr(input logic [11:0] addr, input logic [XLEN-1:0] val);
    i_wb.csr_wen   = 1'b1;
    i_wb.csr_waddr = addr;
    i_wb.csr_wdata = val;
    step();
    i_wb.csr_wen = 1'b0;
  endtask

  task automatic load_inst(input logic [31:0] inst, input logic [XLEN-1:0] pc);
    i_fs_valid = 1'b1;
    i_fs_pkt   = {inst, pc};
    @(negedge i_clk);
    while (!o_ds_allowin) @(negedge i_clk);
    step();
    i_fs_valid = 1'b0;
  endtask

  task automatic wait_issue(output issue_pkt_t pkt, output redirect_t redir);
    @(negedge i_clk);
    while (!(o_ds_valid && i_es_allowin)) @(negedge i_clk);
    pkt   = o_ds_pkt;
    redir = o_redirect;
    step();
  endtask

  task automatic run_inst(input string name, input issue_pkt_t exp, input redirect_t exp_redir);
    issue_pkt_t got;
    redirect_t  redir;
    load_inst(exp.inst, exp.pc);
    wait_issue(got, redir);
    cmp_issue(name, exp, got);
    cmp_redirect(name, exp_redir, redir);
  endtask

  task automatic run_branch(input string name, input issue_pkt_t exp,
                            input redirect_t exp_redir);
    issue_pkt_t got;
    redirect_t  redir;
    load_inst(exp.inst, exp.pc);
    wait_issue(got, redir);
    cmp_redirect(name, exp_redir, redir);
  endtask

  task automatic hazard_case(input string name, input inflight_t inf, input issue_pkt_t exp);
    issue_pkt_t got;
    redirect_t  redir;
    i_inflight = inf;
    load_inst(exp.inst, exp.pc);
    repeat (3) begin
      @(negedge i_clk);
      cmp_bit({name, " valid"}, 1'b0, o_ds_valid);
      cmp_bit({name, " allowin"}, 1'b0, o_ds_allowin);
      cmp_bit({name, " redirect"}, 1'b0, o_redirect.taken);
    end
    step();
    i_inflight = '0;
    wait_issue(got, redir);
    cmp_issue(name, exp, got);
  endtask

  task automatic test_decode();
    issue_pkt_t exp;
    wb_csr(CSR_MSTATUS, 64'h1888);
    exp = exp_pkt(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP_REG));  // add x3, x1, x2
    exp.rd   = 5'd3;
    exp.ctrl = alu_ctrl(SRC1_RS1, SRC2_RS2, 1'b0, ALU_ADD);
    run_inst("add", exp, '0);
    exp = exp_pkt(enc_i(12'hffb, 5'd1, 3'b000, 5'd4, OP_IMM32));  // addiw x4, x1, -5
    exp.rd   = 5'd4;
    exp.imm  = 64'hffff_ffff_ffff_fffb;
    exp.ctrl = alu_ctrl(SRC1_RS1, SRC2_IMM, 1'b1, ALU_ADD);
    run_inst("addiw", exp, '0);
    exp = exp_pkt(enc_i(12'd16, 5'd2, 3'b010, 5'd5, OP_LOAD));  // lw x5, 16(x2)
    exp.rd   = 5'd5;
    exp.imm  = 64'd16;
    exp.ctrl = mem_ctrl(1'b1, 3'b010);
    run_inst("lw", exp, '0);
    exp = exp_pkt(enc_s(12'hff8, 5'd3, 5'd1, 3'b010));  // sw x3, -8(x1)
    exp.imm  = 64'hffff_ffff_ffff_fff8;
    exp.ctrl = mem_ctrl(1'b0, 3'b010);
    run_inst("sw", exp, '0);
    exp = exp_pkt({20'h80000, 5'd6, OP_LUI});
    exp.rd   = 5'd6;
    exp.imm  = 64'hffff_ffff_8000_0000;
    exp.ctrl = alu_ctrl(SRC1_RS1, SRC2_IMM, 1'b0, ALU_LUI);
    run_inst("lui", exp, '0);
    exp = exp_pkt({20'h12345, 5'd7, OP_AUIPC});
    exp.rd   = 5'd7;
    exp.imm  = 64'h1234_5000;
    exp.ctrl = alu_ctrl(SRC1_PC, SRC2_IMM, 1'b0, ALU_ADD);
    run_inst("auipc", exp, '0);
    exp = exp_pkt(enc_i(CSR_MSTATUS, 5'd9, 3'b010, 5'd8, OP_SYSTEM));  // csrrs x8, mstatus, x9
    exp.rd       = 5'd8;
    exp.imm      = 64'd9;
    exp.csr      = CSR_MSTATUS;
    exp.csrrdata = 64'h1888;
    exp.ctrl     = csr_ctrl(CSR_OP_SET, 1'b1);
    run_inst("csrrs", exp, '0);
    exp = exp_pkt(32'hffff_ffff);
    exp.ctrl.invalid = 1'b1;
    run_inst("undefined", exp, '0);
    exp = exp_pkt(32'h0ff0_000f);  // fence iorw, iorw
    run_inst("fence", exp, '0);
  endtask

  task automatic test_x0();
    issue_pkt_t exp;
    wb_gpr(5'd0, 64'hdead_beef_dead_beef);
    exp = exp_pkt(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd9, OP_REG));  // add x9, x0, x0
    exp.rd   = 5'd9;
    exp.ctrl = alu_ctrl(SRC1_RS1, SRC2_RS2, 1'b0, ALU_ADD);
    run_inst("x0 read", exp, '0);
    exp = exp_pkt(enc_s(12'd12, 5'd0, 5'd0, 3'b010));
    exp.imm  = 64'd12;
    exp.ctrl = mem_ctrl(1'b0, 3'b010);
    run_inst("store rd", exp, '0);
    exp = exp_pkt(enc_b(13'd20, 5'd0, 5'd0, 3'b000));  // rd field holds imm bits
    exp.imm  = 64'd20;
    exp.ctrl = br_ctrl(BR_BEQ);
    run_inst("branch rd", exp, {1'b1, exp.pc + 64'd20});
  endtask

  task automatic test_redirect();
    issue_pkt_t exp;
    wb_gpr(5'd11, 64'd5);
    wb_gpr(5'd12, 64'hffff_ffff_ffff_fffd);  // -3
    wb_gpr(5'd13, 64'd5);
    exp = exp_pkt(enc_b(13'd16, 5'd13, 5'd11, 3'b000));
    run_branch("beq taken", exp, {1'b1, exp.pc + 64'd16});
    exp = exp_pkt(enc_b(13'd16, 5'd12, 5'd11, 3'b000));
    run_branch("beq not taken", exp, '0);
    exp = exp_pkt(enc_b(13'h1ff8, 5'd11, 5'd12, 3'b100));  // blt x12, x11
    run_branch("blt taken", exp, {1'b1, exp.pc - 64'd8});
    exp = exp_pkt(enc_b(13'h1ff8, 5'd12, 5'd11, 3'b100));
    run_branch("blt not taken", exp, '0);
    exp = exp_pkt(enc_b(13'd64, 5'd11, 5'd12, 3'b111));  // bgeu x12, x11
    run_branch("bgeu taken", exp, {1'b1, exp.pc + 64'd64});
    exp = exp_pkt(enc_b(13'd64, 5'd12, 5'd11, 3'b111));
    run_branch("bgeu not taken", exp, '0);
    exp = exp_pkt(enc_j(21'd2048, 5'd1));
    run_branch("jal", exp, {1'b1, exp.pc + 64'd2048});
    exp = exp_pkt(enc_i(12'd4, 5'd11, 3'b000, 5'd1, OP_JALR));  // 5 + 4 is odd
    run_branch("jalr", exp, {1'b1, 64'd8});
    exp = exp_pkt(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP_REG));
    run_branch("add no redirect", exp, '0);
  endtask

  task automatic test_hazard();
    issue_pkt_t exp;
    inflight_t  inf;
    inf       = '0;
    inf.es_rd = 5'd11;
    exp = exp_pkt(enc_i(12'd4, 5'd11, 3'b000, 5'd1, OP_JALR));  // jalr x1, 4(x11)
    exp.rd           = 5'd1;
    exp.imm          = 64'd4;
    exp.ctrl         = alu_ctrl(SRC1_RS1, SRC2_FOUR, 1'b0, ALU_ADD);
    exp.ctrl.br_func = BR_JUMP;
    hazard_case("es rd", inf, exp);
    inf       = '0;
    inf.ms_rd = 5'd10;
    exp = exp_pkt(32'h0010_0073);  // ebreak
    exp.ctrl.ebreak = 1'b1;
    hazard_case("ebreak a0", inf, exp);
    inf        = '0;
    inf.ws_csr = CSR_MTVEC;
    exp = exp_pkt(enc_i(CSR_MTVEC, 5'd0, 3'b010, 5'd14, OP_SYSTEM));
    exp.rd       = 5'd14;
    exp.csr      = CSR_MTVEC;
    exp.csrrdata = 64'd0;  // mtvec still at reset
    exp.ctrl     = csr_ctrl(CSR_OP_SET, 1'b0);
    hazard_case("ws csr", inf, exp);
  endtask

  task automatic test_backpressure();
    issue_pkt_t exp_a;
    issue_pkt_t exp_b;
    issue_pkt_t got;
    redirect_t  redir;
    exp_a = exp_pkt(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP_REG));
    exp_a.rd   = 5'd3;
    exp_a.ctrl = alu_ctrl(SRC1_RS1, SRC2_RS2, 1'b0, ALU_ADD);
    exp_b = exp_pkt(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd4, OP_REG));  // sub x4, x2, x1
    exp_b.rd   = 5'd4;
    exp_b.ctrl = alu_ctrl(SRC1_RS1, SRC2_RS2, 1'b0, ALU_SUB);
    i_es_allowin = 1'b0;
    load_inst(exp_a.inst, exp_a.pc);
    i_fs_valid = 1'b1;
    i_fs_pkt   = {exp_b.inst, exp_b.pc};
    repeat (3) begin
      @(negedge i_clk);
      cmp_bit("hold valid", 1'b1, o_ds_valid);
      cmp_bit("hold allowin", 1'b0, o_ds_allowin);
      cmp_issue("hold pkt", exp_a, o_ds_pkt);
    end
    step();
    i_es_allowin = 1'b1;
    wait_issue(got, redir);  // the issuing edge also takes the next packet
    i_fs_valid = 1'b0;
    cmp_issue("release first", exp_a, got);
    wait_issue(got, redir);
    cmp_issue("release second", exp_b, got);
  endtask

  task automatic test_trap();
    issue_pkt_t      exp;
    logic [XLEN-1:0] trap_pc;
    wb_csr(CSR_MTVEC, 64'h8000_1000);
    exp = exp_pkt(32'h0000_0073);  // ecall
    exp.csr         = CSR_MTVEC;
    exp.csrrdata    = 64'h8000_1000;
    exp.ctrl.ecall  = 1'b1;
    run_inst("ecall", exp, {1'b1, 64'h8000_1000});
    trap_pc = exp.pc;
    exp = exp_pkt(enc_i(CSR_MEPC, 5'd0, 3'b010, 5'd15, OP_SYSTEM));
    exp.rd       = 5'd15;
    exp.csr      = CSR_MEPC;
    exp.csrrdata = trap_pc;
    exp.ctrl     = csr_ctrl(CSR_OP_SET, 1'b0);
    run_inst("csrr mepc", exp, '0);
    exp = exp_pkt(enc_i(CSR_MCAUSE, 5'd0, 3'b010, 5'd16, OP_SYSTEM));
    exp.rd       = 5'd16;
    exp.csr      = CSR_MCAUSE;
    exp.csrrdata = 64'd11;  // environment call from M-mode
    exp.ctrl     = csr_ctrl(CSR_OP_SET, 1'b0);
    run_inst("csrr mcause", exp, '0);
    exp = exp_pkt(32'h3020_0073);  // mret
    exp.csr       = CSR_MEPC;
    exp.csrrdata  = trap_pc;
    exp.ctrl.mret = 1'b1;
    run_inst("mret", exp, {1'b1, trap_pc});
  endtask

  initial begin
    i_rst        = 1'b1;
    i_fs_valid   = 1'b0;
    i_fs_pkt     = '0;
    i_es_allowin = 1'b1;
    i_wb         = '0;
    i_inflight   = '0;
    rng_state    = 32'hc1f;
    gpr_model[0] = '0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    @(negedge i_clk);
    cmp_bit("reset valid", 1'b0, o_ds_valid);
    cmp_bit("reset allowin", 1'b1, o_ds_allowin);
    cmp_bit("reset redirect", 1'b0, o_redirect.taken);
    step();
    for (int i = 1; i < 32; i++) begin
      wb_gpr(5'(i), init_val(5'(i)));
    end
    test_decode();
    test_x0();
    test_redirect();
    test_hazard();
    test_backpressure();
    test_trap();
    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* compile.f */
logic/rv_decode_pkg.sv
logic/inst_decoder.sv
logic/gpr_file.sv
logic/csr_file.sv
logic/branch_unit.sv
logic/decode_stage.sv
tests/decode_stage_tb.sv

/* Bender.yml */
package:
  name: rv_decode_stage

sources:
  - files:
      - logic/rv_decode_pkg.sv
      - logic/inst_decoder.sv
      - logic/gpr_file.sv
      - logic/csr_file.sv
      - logic/branch_unit.sv
      - logic/decode_stage.sv
  - target: test
    files:
      - tests/decode_stage_tb.sv
